// File: rtl/vec_pkg.sv
// sizes fixed at 16-byte registers and two lanes; sew code 3 is reserved and never legal
`default_nettype none

package vec_pkg;

  localparam int VLENB     = 16;  // bytes per vector register
  localparam int NUM_VREGS = 32;
  localparam int LANES     = 2;   // set by the two-element ports

  // read value for elements at or beyond vl
  localparam logic [31:0] FILL0 = 32'hDED0DED0;
  localparam logic [31:0] FILL1 = 32'hDED1DED1;

  // element width, same encoding as vsew
  typedef enum logic [1:0] {
    SEW8  = 2'd0,
    SEW16 = 2'd1,
    SEW32 = 2'd2
  } sew_t;

  typedef enum logic [2:0] {
    VADD  = 3'd0,
    VSUB  = 3'd1,  // vs2 - vs1
    VAND  = 3'd2,
    VOR   = 3'd3,
    VXOR  = 3'd4,
    VMAXU = 3'd5
  } vop_t;

  typedef logic [4:0] vreg_idx_t;
  typedef logic [4:0] voff_t;   // element offset
  typedef logic [4:0] vl_t;     // 0 to 16

  typedef logic [LANES-1:0][31:0] elem_pair_t;  // word 0 is element offset+0

  // per-lane enable instead of a single en, so masking can drop one lane
  typedef struct packed {
    logic [LANES-1:0] lane_en;
    vreg_idx_t        vd;
    voff_t            offset;
    sew_t             sew;
    vl_t              vl;
    elem_pair_t       data;
  } vec_wr_t;

  typedef struct packed {
    vreg_idx_t vs;
    voff_t     offset;
    sew_t      sew;
    vl_t       vl;
  } vec_rd_t;

  typedef struct packed {
    vop_t      op;
    logic      vm;   // 1 = masked by v0
    vreg_idx_t vd;
    vreg_idx_t vs1;
    vreg_idx_t vs2;
    sew_t      sew;
    vl_t       vl;
  } vec_instr_t;

  // elements that fit in one register at this width
  function automatic vl_t vlmax_of(input sew_t sew);
    case (sew)
      SEW8:    return vl_t'(VLENB);
      SEW16:   return vl_t'(VLENB / 2);
      SEW32:   return vl_t'(VLENB / 4);
      default: return '0;
    endcase
  endfunction

endpackage

`default_nettype wire

// File: rtl/vec_reg_file.sv
// writes must stay inside VLENB for their sew; reads beyond vl return filler words, not data
`timescale 1ns/10ps
`default_nettype none

module vec_reg_file (
  input  logic                CLK,
  input  logic                nRST,
  input  vec_pkg::vec_wr_t    wr,
  input  vec_pkg::vec_rd_t    rd1,
  input  vec_pkg::vec_rd_t    rd2,
  input  vec_pkg::vec_rd_t    rd3,
  output vec_pkg::elem_pair_t data1,
  output vec_pkg::elem_pair_t data2,
  output vec_pkg::elem_pair_t data3,
  output logic [1:0]          mask_bits,
  input  vec_pkg::voff_t      mask_off
);

  typedef logic [vec_pkg::VLENB-1:0][7:0] vreg_t;

  vreg_t [vec_pkg::NUM_VREGS-1:0] regs;

  logic [vec_pkg::VLENB-1:0]      byte_we;  // byte enables for register wr.vd
  logic [vec_pkg::VLENB-1:0][7:0] byte_wd;
  logic [vec_pkg::VLENB*8-1:0]    v0_bits;

  function automatic int elem_bytes(input vec_pkg::sew_t sew);
    case (sew)
      vec_pkg::SEW8:  return 1;
      vec_pkg::SEW16: return 2;
      default:        return 4;
    endcase
  endfunction

  // two elements from one register, zero-extended, filler past vl
  function automatic vec_pkg::elem_pair_t read_pair(input vreg_t r, input vec_pkg::vec_rd_t rd);
    vec_pkg::elem_pair_t p;
    int nb;
    int base;
    nb = elem_bytes(rd.sew);
    for (int i = 0; i < vec_pkg::LANES; i++) begin
      p[i] = (i == 0) ? vec_pkg::FILL0 : vec_pkg::FILL1;
      if (int'(rd.offset) + i < int'(rd.vl)) begin
        p[i] = '0;
        base = (int'(rd.offset) + i) * nb;
        for (int b = 0; b < 4; b++) begin
          if (b < nb && base + b < vec_pkg::VLENB) begin
            p[i][8*b +: 8] = r[base + b];
          end
        end
      end
    end
    return p;
  endfunction

  // byte lanes touched by the two-element write
  always_comb begin : wr_bytes
    int nb;
    int base;
    byte_we = '0;
    byte_wd = '0;
    nb      = elem_bytes(wr.sew);
    for (int i = 0; i < vec_pkg::LANES; i++) begin
      base = (int'(wr.offset) + i) * nb;
      if (wr.lane_en[i] && (int'(wr.offset) + i < int'(wr.vl))) begin
        for (int b = 0; b < 4; b++) begin
          if (b < nb && base + b < vec_pkg::VLENB) begin
            byte_we[base + b] = 1'b1;
            byte_wd[base + b] = wr.data[i][8*b +: 8];
          end
        end
      end
    end
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      regs <= '0;
    end else begin
      for (int j = 0; j < vec_pkg::VLENB; j++) begin
        if (byte_we[j]) begin
          regs[wr.vd][j] <= byte_wd[j];
        end
      end
    end
  end

  assign data1 = read_pair(regs[rd1.vs], rd1);  // vs1 operand
  assign data2 = read_pair(regs[rd2.vs], rd2);  // vs2 operand
  assign data3 = read_pair(regs[rd3.vs], rd3);  // host store port

  // v0 as a flat bit vector, one bit per element
  assign v0_bits      = regs[0];
  assign mask_bits[0] = v0_bits[mask_off];
  assign mask_bits[1] = v0_bits[int'(mask_off) + 1];

  // whoever drives the port (host or writeback) must keep the element inside the register
  a_wr_lane0_in_range: assert property (@(posedge CLK) disable iff (!nRST)
    (wr.lane_en[0] && (wr.offset < wr.vl))
      |-> ((int'(wr.offset) + 1) * elem_bytes(wr.sew) <= vec_pkg::VLENB));

  a_wr_lane1_in_range: assert property (@(posedge CLK) disable iff (!nRST)
    (wr.lane_en[1] && (int'(wr.offset) + 1 < int'(wr.vl)))
      |-> ((int'(wr.offset) + 2) * elem_bytes(wr.sew) <= vec_pkg::VLENB));

endmodule

`default_nettype wire

// File: rtl/vec_issue.sv
// no handshake; start and host writes while busy are illegal and only caught by assertions
`timescale 1ns/10ps
`default_nettype none

module vec_issue (
  input  logic                  CLK,
  input  logic                  nRST,
  input  logic                  start,
  input  vec_pkg::vec_instr_t   instr,
  input  vec_pkg::vec_wr_t      host_wr,
  input  vec_pkg::vec_wr_t      wb,
  output vec_pkg::vec_rd_t      rd1,
  output vec_pkg::vec_rd_t      rd2,
  output vec_pkg::voff_t        mask_off,
  output logic                  issue,
  output vec_pkg::vop_t         issue_op,
  output vec_pkg::vreg_idx_t    issue_vd,
  output logic                  issue_vm,
  output vec_pkg::vec_wr_t      wr,
  output logic                  busy,
  output logic                  done
);

  vec_pkg::vec_instr_t cur;  // latched instruction
  vec_pkg::voff_t      off_q;
  logic                busy_q;
  logic                done_q;
  logic                issuing_q;
  logic [5:0]          next_off;
  logic                last;

  assign next_off = {1'b0, off_q} + 6'(vec_pkg::LANES);
  assign last     = next_off >= {1'b0, cur.vl};  // this pair finishes vl

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      busy_q    <= 1'b0;
      done_q    <= 1'b0;
      issuing_q <= 1'b0;
      off_q     <= '0;
    end else begin
      done_q <= 1'b0;
      if (start && !busy_q) begin
        busy_q    <= 1'b1;
        off_q     <= '0;
        issuing_q <= (instr.vl != '0);
        done_q    <= (instr.vl == '0);  // empty instruction, nothing to write
      end else if (issuing_q) begin
        off_q <= next_off[4:0];
        if (last) begin
          issuing_q <= 1'b0;
          done_q    <= 1'b1;  // final pair sits in writeback next cycle
        end
      end else if (done_q) begin
        busy_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (start && !busy_q) begin
      cur <= instr;
    end
  end

  assign rd1 = '{vs: cur.vs1, offset: off_q, sew: cur.sew, vl: cur.vl};
  assign rd2 = '{vs: cur.vs2, offset: off_q, sew: cur.sew, vl: cur.vl};

  assign mask_off = off_q;
  assign issue    = issuing_q;
  assign issue_op = cur.op;
  assign issue_vd = cur.vd;
  assign issue_vm = cur.vm;

  // writeback owns the port through the done cycle
  assign wr   = busy_q ? wb : host_wr;
  assign busy = busy_q;
  assign done = done_q;

  a_start_idle: assert property (@(posedge CLK) disable iff (!nRST)
    start |-> !busy_q);

  a_host_wr_idle: assert property (@(posedge CLK) disable iff (!nRST)
    (|host_wr.lane_en) |-> !busy_q);

  a_start_vl: assert property (@(posedge CLK) disable iff (!nRST)
    start |-> (instr.vl <= vec_pkg::vlmax_of(instr.sew)));

endmodule

`default_nettype wire

// File: rtl/vec_lane_alu.sv
// operands arrive zero-extended to 32 bits; vl is only passed on, the register file applies it
`timescale 1ns/10ps
`default_nettype none

module vec_lane_alu (
  input  logic                CLK,
  input  logic                nRST,
  input  logic                issue,
  input  vec_pkg::vop_t       op,
  input  vec_pkg::elem_pair_t a,        // vs2 elements
  input  vec_pkg::elem_pair_t b,        // vs1 elements
  input  logic [1:0]          mask_bits,
  input  logic                vm,
  input  vec_pkg::vreg_idx_t  vd,
  input  vec_pkg::voff_t      offset,
  input  vec_pkg::sew_t       sew,
  input  vec_pkg::vl_t        vl,
  output vec_pkg::vec_wr_t    wb
);

  vec_pkg::elem_pair_t res;
  logic [1:0]          lane_en;

  logic [1:0]          lane_en_q;
  vec_pkg::vreg_idx_t  vd_q;
  vec_pkg::voff_t      off_q;
  vec_pkg::sew_t       sew_q;
  vec_pkg::vl_t        vl_q;
  vec_pkg::elem_pair_t res_q;

  function automatic logic [31:0] lane_op(input vec_pkg::vop_t o, input logic [31:0] x,
                                          input logic [31:0] y);
    case (o)
      vec_pkg::VADD:  return x + y;
      vec_pkg::VSUB:  return x - y;
      vec_pkg::VAND:  return x & y;
      vec_pkg::VOR:   return x | y;
      vec_pkg::VXOR:  return x ^ y;
      vec_pkg::VMAXU: return (x > y) ? x : y;  // unsigned, inputs zero-extended
      default:        return '0;
    endcase
  endfunction

  function automatic logic [31:0] trunc(input vec_pkg::sew_t s, input logic [31:0] w);
    case (s)
      vec_pkg::SEW8:  return {24'h0, w[7:0]};
      vec_pkg::SEW16: return {16'h0, w[15:0]};
      default:        return w;
    endcase
  endfunction

  always_comb begin
    for (int i = 0; i < vec_pkg::LANES; i++) begin
      res[i] = trunc(sew, lane_op(op, a[i], b[i]));
    end
  end

  // masked-off lane is simply not written
  assign lane_en = issue ? (vm ? mask_bits : 2'b11) : 2'b00;

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      lane_en_q <= '0;
    end else begin
      lane_en_q <= lane_en;
    end
  end

  always_ff @(posedge CLK) begin
    vd_q  <= vd;
    off_q <= offset;
    sew_q <= sew;
    vl_q  <= vl;
    res_q <= res;
  end

  assign wb = '{lane_en: lane_en_q, vd: vd_q, offset: off_q, sew: sew_q, vl: vl_q,
                data: res_q};

endmodule

`default_nettype wire

// File: rtl/vec_unit.sv
// one instruction at a time; host writes and start only while busy is low
`timescale 1ns/10ps
`default_nettype none

module vec_unit (
  input  logic                CLK,
  input  logic                nRST,
  input  logic                start,
  input  vec_pkg::vec_instr_t instr,
  input  vec_pkg::vec_wr_t    host_wr,
  input  vec_pkg::vec_rd_t    store_rd,
  output vec_pkg::elem_pair_t store_data,
  output logic                busy,
  output logic                done
);

  vec_pkg::vec_rd_t    rd1;
  vec_pkg::vec_rd_t    rd2;
  vec_pkg::elem_pair_t data1;
  vec_pkg::elem_pair_t data2;
  vec_pkg::voff_t      mask_off;
  logic [1:0]          mask_bits;
  logic                issue;
  vec_pkg::vop_t       issue_op;
  vec_pkg::vreg_idx_t  issue_vd;
  logic                issue_vm;
  vec_pkg::vec_wr_t    wr;   // register file write port
  vec_pkg::vec_wr_t    wb;   // writeback stage

  vec_issue i_issue (
    .CLK      (CLK),
    .nRST     (nRST),
    .start    (start),
    .instr    (instr),
    .host_wr  (host_wr),
    .wb       (wb),
    .rd1      (rd1),
    .rd2      (rd2),
    .mask_off (mask_off),
    .issue    (issue),
    .issue_op (issue_op),
    .issue_vd (issue_vd),
    .issue_vm (issue_vm),
    .wr       (wr),
    .busy     (busy),
    .done     (done)
  );

  vec_reg_file i_rf (
    .CLK       (CLK),
    .nRST      (nRST),
    .wr        (wr),
    .rd1       (rd1),
    .rd2       (rd2),
    .rd3       (store_rd),
    .data1     (data1),
    .data2     (data2),
    .data3     (store_data),
    .mask_bits (mask_bits),
    .mask_off  (mask_off)
  );

  // offset, sew and vl ride along with the vs1 read request
  vec_lane_alu i_alu (
    .CLK       (CLK),
    .nRST      (nRST),
    .issue     (issue),
    .op        (issue_op),
    .a         (data2),
    .b         (data1),
    .mask_bits (mask_bits),
    .vm        (issue_vm),
    .vd        (issue_vd),
    .offset    (rd1.offset),
    .sew       (rd1.sew),
    .vl        (rd1.vl),
    .wb        (wb)
  );

endmodule

`default_nettype wire

// File: bench/vec_model.svh
// shadow model of the register file; assumes every write stays inside VLENB for its sew
`ifndef VEC_MODEL_SVH
`define VEC_MODEL_SVH

// element e at width sew starts at byte e * (1 << sew)
logic [vec_pkg::VLENB-1:0][7:0] shadow [vec_pkg::NUM_VREGS];

function automatic logic [31:0] elem_get(input int vs, input int e, input vec_pkg::sew_t sew);
  logic [31:0] v;
  v = '0;  // zero-extended
  for (int b = 0; b < (1 << sew); b++) begin
    v[8*b +: 8] = shadow[vs][e * (1 << sew) + b];
  end
  return v;
endfunction

task automatic elem_put(input int vd, input int e, input vec_pkg::sew_t sew,
                        input logic [31:0] v);
  for (int b = 0; b < (1 << sew); b++) begin
    shadow[vd][e * (1 << sew) + b] = v[8*b +: 8];
  end
endtask

function automatic vec_pkg::elem_pair_t expect_read(input vec_pkg::vec_rd_t rd);
  vec_pkg::elem_pair_t p;
  for (int i = 0; i < 2; i++) begin
    if (int'(rd.offset) + i < int'(rd.vl)) begin
      p[i] = elem_get(rd.vs, int'(rd.offset) + i, rd.sew);
    end else begin
      p[i] = (i == 0) ? 32'hDED0DED0 : 32'hDED1DED1;  // past vl
    end
  end
  return p;
endfunction

task automatic apply_host_write(input vec_pkg::vec_wr_t w);
  for (int i = 0; i < 2; i++) begin
    if (w.lane_en[i] && (int'(w.offset) + i < int'(w.vl))) begin
      elem_put(w.vd, int'(w.offset) + i, w.sew, w.data[i]);
    end
  end
endtask

// x is the vs2 element, y the vs1 element
function automatic logic [31:0] alu_result(input vec_pkg::vop_t op, input logic [31:0] x,
                                           input logic [31:0] y, input vec_pkg::sew_t sew);
  logic [31:0] r;
  logic [63:0] keep;
  keep = (64'd1 << (8 << sew)) - 64'd1;  // low sew bits
  case (op)
    vec_pkg::VADD: r = x + y;
    vec_pkg::VSUB: r = x - y;
    vec_pkg::VAND: r = x & y;
    vec_pkg::VOR:  r = x | y;
    vec_pkg::VXOR: r = x ^ y;
    default:       r = (x > y) ? x : y;
  endcase
  return r & keep[31:0];
endfunction

task automatic execute_instr(input vec_pkg::vec_instr_t ins);
  logic [31:0] res [16];
  logic        we [16];
  for (int e = 0; e < int'(ins.vl); e++) begin
    res[e] = alu_result(ins.op, elem_get(ins.vs2, e, ins.sew),
                        elem_get(ins.vs1, e, ins.sew), ins.sew);
    we[e]  = !ins.vm || shadow[0][e / 8][e % 8];
  end
  // all results were taken from the old values, so vd may alias a source
  for (int e = 0; e < int'(ins.vl); e++) begin
    if (we[e]) begin
      elem_put(ins.vd, e, ins.sew, res[e]);
    end
  end
endtask

`endif

// File: bench/vec_unit_tb.sv
// random stimulus from a fixed seed, checked against the shadow model; stops at the first error
`timescale 1ns/10ps
`default_nettype none

module vec_unit_tb;

  localparam int NUM_WR         = 200;
  localparam int NUM_INSTR      = 144;  // every opcode and sew, masked and unmasked
  localparam int NUM_TESTS      = 2 * vec_pkg::NUM_VREGS + NUM_WR + 3 * NUM_INSTR;
  localparam int TIMEOUT_CYCLES = NUM_TESTS * (vec_pkg::VLENB / 2 + 4) + 100;

  logic                CLK = 1'b0;
  logic                nRST;
  logic                start;
  logic                busy;
  logic                done;
  vec_pkg::vec_instr_t instr;
  vec_pkg::vec_wr_t    host_wr;
  vec_pkg::vec_rd_t    store_rd;
  vec_pkg::elem_pair_t store_data;
  int                  seed = 32'h596c00ac;

  `include "vec_model.svh"

  vec_unit i_dut (.*);

  always #10 CLK = ~CLK;

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("MISMATCH %s: got %h, expected %h", name, got, exp);
      $display("Test FAILED");
      $fatal(1, "stopped at first mismatch");
    end
  endtask

  task automatic check_pair(input string name, input vec_pkg::elem_pair_t got,
                            input vec_pkg::elem_pair_t exp);
    if (got !== exp) begin
      $display("MISMATCH %s: got %h, expected %h", name, got, exp);
      $display("Test FAILED");
      $fatal(1, "stopped at first mismatch");
    end
  endtask

  function automatic int rand_below(input int n);
    logic [31:0] r;
    r = $random(seed);
    return int'(r % n);
  endfunction

  task automatic host_write(input vec_pkg::vec_wr_t w);
    @(posedge CLK);
    host_wr <= w;
    @(posedge CLK);
    host_wr.lane_en <= '0;
    apply_host_write(w);
  endtask

  task automatic store_check(input int vs, input int off, input vec_pkg::sew_t s, input int vl);
    vec_pkg::vec_rd_t rd;
    rd = '{vs: 5'(vs), offset: 5'(off), sew: s, vl: 5'(vl)};
    @(posedge CLK);
    store_rd <= rd;
    @(negedge CLK);
    check_pair("store_data", store_data, expect_read(rd));
  endtask

  // whole register with random words, two sew 32 pairs
  task automatic fill_reg(input int vd);
    vec_pkg::vec_wr_t w;
    for (int off = 0; off < 4; off += 2) begin
      w = '{lane_en: 2'b11, vd: 5'(vd), offset: 5'(off), sew: vec_pkg::SEW32, vl: 5'd4,
            data: {$random(seed), $random(seed)}};
      host_write(w);
    end
  endtask

  task automatic random_host_write();
    vec_pkg::vec_wr_t w;
    int vmax;
    w.sew     = vec_pkg::sew_t'(rand_below(3));
    vmax      = vec_pkg::VLENB >> w.sew;
    w.lane_en = 2'(rand_below(4));
    w.vd      = 5'(rand_below(vec_pkg::NUM_VREGS));
    w.vl      = 5'(rand_below(vmax + 1));
    w.offset  = 5'(rand_below(vmax));
    w.data    = {$random(seed), $random(seed)};
    host_write(w);
    store_check(w.vd, w.offset, w.sew, vmax);  // covers elements past the write's vl
    store_check(w.vd, rand_below(vmax), w.sew, rand_below(vmax + 1));
  endtask

  // busy and done checked every cycle against the issue timing
  task automatic run_instr(input vec_pkg::vec_instr_t ins);
    int n;
    n = (int'(ins.vl) + 1) / 2;
    @(posedge CLK);
    start <= 1'b1;
    instr <= ins;
    for (int c = 0; c <= n + 2; c++) begin
      @(negedge CLK);
      check_flag("busy", busy, (c >= 1) && (c <= n + 1));
      check_flag("done", done, c == n + 1);
      @(posedge CLK);
      start <= 1'b0;
    end
    execute_instr(ins);
  endtask

  task automatic random_instr(input int i);
    vec_pkg::vec_instr_t ins;
    int vmax;
    ins.op  = vec_pkg::vop_t'(i % 6);
    ins.sew = vec_pkg::sew_t'((i / 6) % 3);
    ins.vm  = 1'((i / 18) % 2);
    vmax    = vec_pkg::VLENB >> ins.sew;
    ins.vl  = 5'(rand_below(vmax + 1));
    ins.vs1 = 5'(rand_below(vec_pkg::NUM_VREGS));
    ins.vs2 = 5'(rand_below(vec_pkg::NUM_VREGS));
    case (rand_below(4))
      0:       ins.vd = ins.vs1;  // in place on an operand
      1:       ins.vd = ins.vs2;
      default: ins.vd = 5'(rand_below(vec_pkg::NUM_VREGS));
    endcase
    if (ins.vm) begin
      if (ins.vd == '0) begin
        ins.vd = 5'd1;  // v0 stays the mask source
      end
      fill_reg(0);
    end
    run_instr(ins);
    for (int off = 0; off < vmax; off += 2) begin
      store_check(ins.vd, off, ins.sew, vmax);
    end
  endtask

  initial begin : main
    nRST     = 1'b0;
    start    = 1'b0;
    instr    = '0;
    host_wr  = '0;
    store_rd = '0;
    foreach (shadow[r]) begin
      shadow[r] = '0;
    end
    repeat (10) @(posedge CLK);
    nRST <= 1'b1;
    @(negedge CLK);
    check_flag("busy", busy, 1'b0);
    check_flag("done", done, 1'b0);
    for (int r = 0; r < vec_pkg::NUM_VREGS; r++) begin
      store_check(r, 0, vec_pkg::SEW8, 16);
    end
    for (int r = 0; r < vec_pkg::NUM_VREGS; r++) begin
      fill_reg(r);
    end
    for (int k = 0; k < NUM_WR; k++) begin
      random_host_write();
    end
    for (int i = 0; i < NUM_INSTR; i++) begin
      random_instr(i);
    end
    $display("Test OK");
    $finish;
  end

  initial begin : watchdog
    repeat (TIMEOUT_CYCLES) @(posedge CLK);
    $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("Test FAILED");
    $fatal(1, "watchdog expired");
  end

endmodule

`default_nettype wire

// File: all.f
+incdir+bench
rtl/vec_pkg.sv
rtl/vec_reg_file.sv
rtl/vec_issue.sv
rtl/vec_lane_alu.sv
rtl/vec_unit.sv
bench/vec_unit_tb.sv
